//--- lc4_pipeline.f
verilog/lc4_pkg.sv
verilog/lc4_fetch.sv
verilog/lc4_regfile.sv
verilog/lc4_decode.sv
verilog/lc4_execute.sv
verilog/lc4_writeback.sv
verilog/lc4_pipeline.sv
tests/tb_clock.sv
tests/tb_lc4_pipeline.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f lc4_pipeline.f --top-module tb_lc4_pipeline -o sim_lc4

out=$(./obj_dir/sim_lc4 || true)
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

//--- tests/tb_lc4_pipeline.sv
`timescale 1ns/1ps

module tb_lc4_pipeline;

    localparam lc4_pkg::word_t PROG_END = lc4_pkg::RESET_PC + 16'd256;

    logic                 gwe;
    logic                 i_reset;
    lc4_pkg::word_t       i_imem_insn;
    lc4_pkg::word_t       i_dmem_rdata;
    lc4_pkg::word_t       o_imem_addr;
    lc4_pkg::word_t       o_dmem_addr;
    logic                 o_dmem_we;
    lc4_pkg::word_t       o_dmem_wdata;
    lc4_pkg::word_t       o_wb_pc;
    lc4_pkg::word_t       o_wb_insn;
    lc4_pkg::stall_code_t o_wb_stall;
    logic                 o_wb_regfile_we;
    lc4_pkg::reg_idx_t    o_wb_wsel;
    lc4_pkg::word_t       o_wb_data;
    logic                 o_wb_dmem_we;
    lc4_pkg::word_t       o_wb_dmem_addr;
    lc4_pkg::word_t       o_wb_dmem_data;

    lc4_pkg::word_t    program_mem [0:255];
    lc4_pkg::word_t    data_mem [0:255];
    lc4_pkg::word_t    model_dmem [0:255];
    lc4_pkg::word_t    model_regs [0:7];
    lc4_pkg::word_t    model_pc;
    lc4_pkg::nzp_t     model_nzp;
    logic [15:0]       lfsr;
    int                flush_seen;
    int                load_seen;
    logic              first_retire;
    logic              prev_taken;
    logic              prev_load;
    lc4_pkg::reg_idx_t prev_wsel;

    tb_clock clock0 (.o_gwe(gwe), .o_reset(i_reset));

    lc4_pipeline dut0 (
        .gwe(gwe), .i_reset(i_reset), .i_imem_insn(i_imem_insn), .i_dmem_rdata(i_dmem_rdata),
        .o_imem_addr(o_imem_addr), .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata), .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn),
        .o_wb_stall(o_wb_stall), .o_wb_regfile_we(o_wb_regfile_we), .o_wb_wsel(o_wb_wsel),
        .o_wb_data(o_wb_data), .o_wb_dmem_we(o_wb_dmem_we), .o_wb_dmem_addr(o_wb_dmem_addr),
        .o_wb_dmem_data(o_wb_dmem_data)
    );

    // instruction memory, zeros outside the program
    always_comb begin
        if (o_imem_addr >= lc4_pkg::RESET_PC && o_imem_addr < PROG_END) begin
            i_imem_insn = program_mem[o_imem_addr[7:0]];
        end else begin
            i_imem_insn = 16'h0000;
        end
    end

    assign i_dmem_rdata = data_mem[o_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            data_mem[o_dmem_addr[7:0]] <= o_dmem_wdata;
        end
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    function automatic lc4_pkg::word_t random_insn();
        logic [2:0] kind;
        logic [2:0] rd;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [1:0] lop;
        kind = 3'(take_bits(3));
        rd   = 3'(take_bits(3));
        rs   = 3'(take_bits(3));
        rt   = 3'(take_bits(3));
        case (kind)
            3'd0: return {4'b0001, rd, rs, 1'b0, 1'(take_bits(1)), 1'b0, rt};
            3'd1: return {4'b0001, rd, rs, 1'b1, 5'(take_bits(5))};
            3'd2: begin
                lop = 2'(take_bits(2));
                // 01 would be not, which is outside the subset
                if (lop == 2'b01) begin
                    lop = 2'b11;
                end
                return {4'b0101, rd, rs, 1'b0, lop, rt};
            end
            3'd3: return {4'b0101, rd, rs, 1'b1, 5'(take_bits(5))};
            3'd4: return {4'b1001, rd, 9'(take_bits(9))};
            3'd5: return {4'b0110, rd, rs, 6'(take_bits(6))};
            3'd6: return {4'b0111, rt, rs, 6'(take_bits(6))};
            default: return {4'b0000, rd, 6'b000000, 3'(take_bits(3))};
        endcase
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            fail_stop($sformatf("Fail time=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    // waits for the next real slot on the trace, counting bubbles on the way
    task automatic wait_retire();
        int   cycles;
        logic done;
        cycles     = 0;
        done       = 1'b0;
        flush_seen = 0;
        load_seen  = 0;
        while (!done) begin
            @(negedge gwe);
            cycles++;
            if (o_wb_stall == lc4_pkg::STALL_NONE) begin
                done = 1'b1;
            end else begin
                assert (!o_wb_regfile_we && !o_wb_dmem_we) else begin
                    fail_stop($sformatf("a bubble on the trace set a write enable at %0t", $time));
                end
                assert (!first_retire || o_wb_stall == lc4_pkg::STALL_FLUSH) else begin
                    fail_stop("a slot before the first retire was not a flush bubble");
                end
                if (o_wb_stall == lc4_pkg::STALL_FLUSH) begin
                    flush_seen++;
                end else begin
                    load_seen++;
                end
                if (cycles > 20) begin
                    fail_stop("timeout waiting for an instruction to retire");
                end
            end
        end
    endtask

    // true when insn reads register w, or is a branch
    function automatic logic reads_reg(input lc4_pkg::word_t insn, input lc4_pkg::reg_idx_t w);
        case (insn[15:12])
            4'b0001, 4'b0101: return insn[8:6] == w || (!insn[5] && insn[2:0] == w);
            4'b0110, 4'b0111: return insn[8:6] == w;
            4'b0000: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic retire_one();
        lc4_pkg::word_t insn;
        lc4_pkg::word_t a;
        lc4_pkg::word_t b;
        lc4_pkg::word_t res;
        lc4_pkg::word_t addr;
        lc4_pkg::word_t mdata;
        lc4_pkg::word_t next_pc;
        logic           exp_we;
        logic           exp_dwe;
        logic           is_ld;
        logic           taken;
        insn    = (model_pc < PROG_END) ? program_mem[model_pc[7:0]] : 16'h0000;
        a       = model_regs[insn[8:6]];
        b       = model_regs[insn[2:0]];
        res     = '0;
        addr    = '0;
        mdata   = '0;
        exp_we  = 1'b0;
        exp_dwe = 1'b0;
        is_ld   = 1'b0;
        taken   = 1'b0;
        next_pc = model_pc + 16'd1;
        case (insn[15:12])
            4'b0001: begin
                exp_we = 1'b1;
                res = insn[5] ? a + {{11{insn[4]}}, insn[4:0]} : (insn[4] ? a - b : a + b);
            end
            4'b0101: begin
                exp_we = 1'b1;
                if (insn[5]) res = a & {{11{insn[4]}}, insn[4:0]};
                else if (insn[4:3] == 2'b00) res = a & b;
                else if (insn[4:3] == 2'b10) res = a | b;
                else res = a ^ b;
            end
            4'b1001: begin
                exp_we = 1'b1;
                res    = {{7{insn[8]}}, insn[8:0]};
            end
            4'b0110: begin
                exp_we = 1'b1;
                is_ld  = 1'b1;
                addr   = a + {{10{insn[5]}}, insn[5:0]};
                res    = model_dmem[addr[7:0]];
                mdata  = res;
            end
            4'b0111: begin
                exp_dwe = 1'b1;
                addr    = a + {{10{insn[5]}}, insn[5:0]};
                mdata   = model_regs[insn[11:9]];
            end
            4'b0000: begin
                taken = |(insn[11:9] & model_nzp);
                if (taken) next_pc = model_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
            end
            default: ;
        endcase

        wait_retire();
        if (!first_retire) begin
            check_value("flush bubbles", 16'(flush_seen), prev_taken ? 16'd2 : 16'd0);
            check_value("load bubbles", 16'(load_seen),
                        (prev_load && reads_reg(insn, prev_wsel)) ? 16'd1 : 16'd0);
        end
        check_value("o_wb_pc", o_wb_pc, model_pc);
        check_value("o_wb_insn", o_wb_insn, insn);
        check_value("o_wb_regfile_we", 16'(o_wb_regfile_we), 16'(exp_we));
        if (exp_we) begin
            check_value("o_wb_wsel", 16'(o_wb_wsel), 16'(insn[11:9]));
            check_value("o_wb_data", o_wb_data, res);
        end
        check_value("o_wb_dmem_we", 16'(o_wb_dmem_we), 16'(exp_dwe));
        if (is_ld || exp_dwe) begin
            check_value("o_wb_dmem_addr", o_wb_dmem_addr, addr);
            check_value("o_wb_dmem_data", o_wb_dmem_data, mdata);
        end

        if (exp_we) begin
            model_regs[insn[11:9]] = res;
            model_nzp = {res[15], res == 16'd0, !res[15] && res != 16'd0};
        end
        if (exp_dwe) begin
            model_dmem[addr[7:0]] = mdata;
        end
        first_retire = 1'b0;
        prev_taken   = taken;
        prev_load    = is_ld;
        prev_wsel    = insn[11:9];
        model_pc     = next_pc;
    endtask

    initial begin
        int             cycles;
        lc4_pkg::word_t w;
        lfsr         = 16'd40816;
        first_retire = 1'b1;
        prev_taken   = 1'b0;
        prev_load    = 1'b0;
        prev_wsel    = '0;
        model_pc     = lc4_pkg::RESET_PC;
        model_nzp    = '0;
        for (int i = 0; i < 256; i++) begin
            w              = 16'(i);
            program_mem[i] = random_insn();
            data_mem[i]   <= {w[7:0], ~w[7:0]};
            model_dmem[i]  = {w[7:0], ~w[7:0]};
        end
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end

        cycles = 0;
        @(negedge gwe);
        while (i_reset) begin
            @(negedge gwe);
            cycles++;
            if (cycles > 10) begin
                fail_stop("timeout waiting for reset to end");
            end
        end

        while (model_pc < PROG_END) begin
            retire_one();
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic o_gwe,
    output logic o_reset
);

    initial begin
        o_gwe = 1'b0;
        forever #5 o_gwe = ~o_gwe;
    end

    // reset held for three rising edges
    initial begin
        o_reset <= 1'b1;
        repeat (3) @(posedge o_gwe);
        o_reset <= 1'b0;
    end

endmodule

//--- verilog/lc4_pipeline.sv
`timescale 1ns/1ps

module lc4_pipeline (
    input  logic                 gwe,
    input  logic                 i_reset,
    input  lc4_pkg::word_t       i_imem_insn,
    input  lc4_pkg::word_t       i_dmem_rdata,
    output lc4_pkg::word_t       o_imem_addr,
    output lc4_pkg::word_t       o_dmem_addr,
    output logic                 o_dmem_we,
    output lc4_pkg::word_t       o_dmem_wdata,
    output lc4_pkg::word_t       o_wb_pc,
    output lc4_pkg::word_t       o_wb_insn,
    output lc4_pkg::stall_code_t o_wb_stall,
    output logic                 o_wb_regfile_we,
    output lc4_pkg::reg_idx_t    o_wb_wsel,
    output lc4_pkg::word_t       o_wb_data,
    output logic                 o_wb_dmem_we,
    output lc4_pkg::word_t       o_wb_dmem_addr,
    output lc4_pkg::word_t       o_wb_dmem_data
);

    logic                 load_stall, redirect;
    lc4_pkg::word_t       redirect_pc, d_pc, d_insn;
    lc4_pkg::stall_code_t d_stall, x_stall, m_stall;
    lc4_pkg::word_t       x_pc, x_insn, x_rs_data, x_rt_data;
    lc4_pkg::reg_idx_t    x_rs_sel, x_rt_sel, x_wsel;
    logic                 x_rs_re, x_rt_re, x_regfile_we, x_nzp_we;
    logic                 x_is_load, x_is_store, x_is_branch;
    lc4_pkg::word_t       m_pc, m_insn, m_alu, m_store_data, m_result;
    lc4_pkg::reg_idx_t    m_wsel, m_byp_wsel, w_wsel;
    logic                 m_regfile_we, m_is_load, m_is_store, m_we, w_we;
    lc4_pkg::word_t       w_data;

    lc4_fetch fetch0 (
        .gwe(gwe), .i_reset(i_reset), .i_load_stall(load_stall), .i_redirect(redirect),
        .i_redirect_pc(redirect_pc), .i_imem_insn(i_imem_insn), .o_imem_addr(o_imem_addr),
        .o_d_pc(d_pc), .o_d_insn(d_insn), .o_d_stall(d_stall)
    );

    lc4_decode decode0 (
        .gwe(gwe), .i_reset(i_reset), .i_d_pc(d_pc), .i_d_insn(d_insn), .i_d_stall(d_stall),
        .i_flush(redirect), .i_w_we(w_we), .i_w_wsel(w_wsel), .i_w_data(w_data),
        .o_load_stall(load_stall), .o_x_pc(x_pc), .o_x_insn(x_insn), .o_x_stall(x_stall),
        .o_x_rs_sel(x_rs_sel), .o_x_rt_sel(x_rt_sel), .o_x_rs_re(x_rs_re),
        .o_x_rt_re(x_rt_re), .o_x_wsel(x_wsel), .o_x_regfile_we(x_regfile_we),
        .o_x_nzp_we(x_nzp_we), .o_x_is_load(x_is_load), .o_x_is_store(x_is_store),
        .o_x_is_branch(x_is_branch), .o_x_rs_data(x_rs_data), .o_x_rt_data(x_rt_data)
    );

    lc4_execute execute0 (
        .gwe(gwe), .i_reset(i_reset), .i_x_pc(x_pc), .i_x_insn(x_insn), .i_x_stall(x_stall),
        .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel), .i_x_rs_re(x_rs_re),
        .i_x_rt_re(x_rt_re), .i_x_wsel(x_wsel), .i_x_regfile_we(x_regfile_we),
        .i_x_nzp_we(x_nzp_we), .i_x_is_load(x_is_load), .i_x_is_store(x_is_store),
        .i_x_is_branch(x_is_branch), .i_x_rs_data(x_rs_data), .i_x_rt_data(x_rt_data),
        .i_m_we(m_we), .i_m_wsel(m_byp_wsel), .i_m_result(m_result),
        .i_w_we(w_we), .i_w_wsel(w_wsel), .i_w_data(w_data),
        .i_m_is_load(m_is_load), .i_dmem_rdata(i_dmem_rdata),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_m_pc(m_pc), .o_m_insn(m_insn), .o_m_stall(m_stall), .o_m_wsel(m_wsel),
        .o_m_regfile_we(m_regfile_we), .o_m_is_load(m_is_load), .o_m_is_store(m_is_store),
        .o_m_alu(m_alu), .o_m_store_data(m_store_data)
    );

    lc4_writeback writeback0 (
        .gwe(gwe), .i_reset(i_reset), .i_m_pc(m_pc), .i_m_insn(m_insn), .i_m_stall(m_stall),
        .i_m_wsel(m_wsel), .i_m_regfile_we(m_regfile_we), .i_m_is_load(m_is_load),
        .i_m_is_store(m_is_store), .i_m_alu(m_alu), .i_m_store_data(m_store_data),
        .i_dmem_rdata(i_dmem_rdata), .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we),
        .o_dmem_wdata(o_dmem_wdata), .o_m_we(m_we), .o_m_wsel(m_byp_wsel),
        .o_m_result(m_result), .o_w_we(w_we), .o_w_wsel(w_wsel), .o_w_data(w_data),
        .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn), .o_wb_stall(o_wb_stall),
        .o_wb_regfile_we(o_wb_regfile_we), .o_wb_wsel(o_wb_wsel), .o_wb_data(o_wb_data),
        .o_wb_dmem_we(o_wb_dmem_we), .o_wb_dmem_addr(o_wb_dmem_addr),
        .o_wb_dmem_data(o_wb_dmem_data)
    );

endmodule

//--- verilog/lc4_writeback.sv
`timescale 1ns/1ps

module lc4_writeback (
    input  logic                 gwe,
    input  logic                 i_reset,
    input  lc4_pkg::word_t       i_m_pc,
    input  lc4_pkg::word_t       i_m_insn,
    input  lc4_pkg::stall_code_t i_m_stall,
    input  lc4_pkg::reg_idx_t    i_m_wsel,
    input  logic                 i_m_regfile_we,
    input  logic                 i_m_is_load,
    input  logic                 i_m_is_store,
    input  lc4_pkg::word_t       i_m_alu,
    input  lc4_pkg::word_t       i_m_store_data,
    input  lc4_pkg::word_t       i_dmem_rdata,
    output lc4_pkg::word_t       o_dmem_addr,
    output logic                 o_dmem_we,
    output lc4_pkg::word_t       o_dmem_wdata,
    output logic                 o_m_we,
    output lc4_pkg::reg_idx_t    o_m_wsel,
    output lc4_pkg::word_t       o_m_result,
    output logic                 o_w_we,
    output lc4_pkg::reg_idx_t    o_w_wsel,
    output lc4_pkg::word_t       o_w_data,
    output lc4_pkg::word_t       o_wb_pc,
    output lc4_pkg::word_t       o_wb_insn,
    output lc4_pkg::stall_code_t o_wb_stall,
    output logic                 o_wb_regfile_we,
    output lc4_pkg::reg_idx_t    o_wb_wsel,
    output lc4_pkg::word_t       o_wb_data,
    output logic                 o_wb_dmem_we,
    output lc4_pkg::word_t       o_wb_dmem_addr,
    output lc4_pkg::word_t       o_wb_dmem_data
);

    lc4_pkg::word_t wb_alu;
    lc4_pkg::word_t wb_load_data;
    logic           wb_is_load;

    // a load's alu value is its address, so it is kept off the mx path
    assign o_m_we     = i_m_regfile_we && !i_m_is_load;
    assign o_m_wsel   = i_m_wsel;
    assign o_m_result = i_m_alu;

    // for a store the wsel field carries the data register
    assign o_dmem_addr  = (i_m_is_load || i_m_is_store) ? i_m_alu : 16'h0000;
    assign o_dmem_we    = i_m_is_store;
    assign o_dmem_wdata = !i_m_is_store ? 16'h0000 :
                          (o_w_we && o_w_wsel == i_m_wsel) ? o_w_data : i_m_store_data;

    always_ff @(posedge gwe) begin
        o_wb_pc        <= i_m_pc;
        o_wb_insn      <= i_m_insn;
        o_wb_wsel      <= i_m_wsel;
        wb_alu         <= i_m_alu;
        wb_load_data   <= i_dmem_rdata;
        o_wb_dmem_addr <= o_dmem_addr;
        o_wb_dmem_data <= i_m_is_load ? i_dmem_rdata : o_dmem_wdata;
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_wb_stall      <= lc4_pkg::STALL_FLUSH;
            o_wb_regfile_we <= 1'b0;
            o_wb_dmem_we    <= 1'b0;
            wb_is_load      <= 1'b0;
        end else begin
            o_wb_stall      <= i_m_stall;
            o_wb_regfile_we <= i_m_regfile_we;
            o_wb_dmem_we    <= i_m_is_store;
            wb_is_load      <= i_m_is_load;
        end
    end

    assign o_wb_data = wb_is_load ? wb_load_data : wb_alu;

    assign o_w_we   = o_wb_regfile_we;
    assign o_w_wsel = o_wb_wsel;
    assign o_w_data = o_wb_data;

endmodule

//--- verilog/lc4_execute.sv
`timescale 1ns/1ps

module lc4_execute (
    input  logic                 gwe,
    input  logic                 i_reset,
    input  lc4_pkg::word_t       i_x_pc,
    input  lc4_pkg::word_t       i_x_insn,
    input  lc4_pkg::stall_code_t i_x_stall,
    input  lc4_pkg::reg_idx_t    i_x_rs_sel,
    input  lc4_pkg::reg_idx_t    i_x_rt_sel,
    input  logic                 i_x_rs_re,
    input  logic                 i_x_rt_re,
    input  lc4_pkg::reg_idx_t    i_x_wsel,
    input  logic                 i_x_regfile_we,
    input  logic                 i_x_nzp_we,
    input  logic                 i_x_is_load,
    input  logic                 i_x_is_store,
    input  logic                 i_x_is_branch,
    input  lc4_pkg::word_t       i_x_rs_data,
    input  lc4_pkg::word_t       i_x_rt_data,
    input  logic                 i_m_we,
    input  lc4_pkg::reg_idx_t    i_m_wsel,
    input  lc4_pkg::word_t       i_m_result,
    input  logic                 i_w_we,
    input  lc4_pkg::reg_idx_t    i_w_wsel,
    input  lc4_pkg::word_t       i_w_data,
    input  logic                 i_m_is_load,
    input  lc4_pkg::word_t       i_dmem_rdata,
    output logic                 o_redirect,
    output lc4_pkg::word_t       o_redirect_pc,
    output lc4_pkg::word_t       o_m_pc,
    output lc4_pkg::word_t       o_m_insn,
    output lc4_pkg::stall_code_t o_m_stall,
    output lc4_pkg::reg_idx_t    o_m_wsel,
    output logic                 o_m_regfile_we,
    output logic                 o_m_is_load,
    output logic                 o_m_is_store,
    output lc4_pkg::word_t       o_m_alu,
    output lc4_pkg::word_t       o_m_store_data
);

    function automatic lc4_pkg::nzp_t sign_bits(input lc4_pkg::word_t v);
        return {v[15], v == 16'd0, !v[15] && v != 16'd0};
    endfunction

    lc4_pkg::word_t rs_val;
    lc4_pkg::word_t rt_val;
    lc4_pkg::word_t alu;
    lc4_pkg::word_t imm5;
    lc4_pkg::word_t imm6;
    lc4_pkg::word_t imm9;
    lc4_pkg::nzp_t  nzp;

    // mx first, then wx, then the register file value
    assign rs_val = (i_x_rs_re && i_m_we && i_m_wsel == i_x_rs_sel) ? i_m_result :
                    (i_x_rs_re && i_w_we && i_w_wsel == i_x_rs_sel) ? i_w_data : i_x_rs_data;
    assign rt_val = (i_x_rt_re && i_m_we && i_m_wsel == i_x_rt_sel) ? i_m_result :
                    (i_x_rt_re && i_w_we && i_w_wsel == i_x_rt_sel) ? i_w_data : i_x_rt_data;

    assign imm5 = {{11{i_x_insn[4]}}, i_x_insn[4:0]};
    assign imm6 = {{10{i_x_insn[5]}}, i_x_insn[5:0]};
    assign imm9 = {{7{i_x_insn[8]}}, i_x_insn[8:0]};

    always_comb begin
        case (i_x_insn[15:12])
            lc4_pkg::OPC_ARITH: alu = i_x_insn[5] ? rs_val + imm5 :
                                      i_x_insn[4] ? rs_val - rt_val : rs_val + rt_val;
            lc4_pkg::OPC_LOGIC: alu = i_x_insn[5]      ? rs_val & imm5 :
                                      !i_x_insn[4]     ? rs_val & rt_val :
                                      i_x_insn[3]      ? rs_val ^ rt_val : rs_val | rt_val;
            lc4_pkg::OPC_CONST: alu = imm9;
            lc4_pkg::OPC_LDR, lc4_pkg::OPC_STR: alu = rs_val + imm6;
            // branch target
            lc4_pkg::OPC_BR: alu = i_x_pc + 16'd1 + imm9;
            default: alu = '0;
        endcase
    end

    // the younger alu writer overrides a load leaving memory on the same edge
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp <= '0;
        end else if (i_x_nzp_we && !i_x_is_load) begin
            nzp <= sign_bits(alu);
        end else if (i_m_is_load) begin
            nzp <= sign_bits(i_dmem_rdata);
        end
    end

    assign o_redirect    = i_x_is_branch && |(i_x_insn[11:9] & nzp);
    assign o_redirect_pc = alu;

    always_ff @(posedge gwe) begin
        o_m_pc         <= i_x_pc;
        o_m_insn       <= i_x_insn;
        o_m_wsel       <= i_x_wsel;
        o_m_alu        <= alu;
        o_m_store_data <= rt_val;
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_m_stall      <= lc4_pkg::STALL_FLUSH;
            o_m_regfile_we <= 1'b0;
            o_m_is_load    <= 1'b0;
            o_m_is_store   <= 1'b0;
        end else begin
            o_m_stall      <= i_x_stall;
            o_m_regfile_we <= i_x_regfile_we;
            o_m_is_load    <= i_x_is_load;
            o_m_is_store   <= i_x_is_store;
        end
    end

endmodule

//--- verilog/lc4_decode.sv
`timescale 1ns/1ps

module lc4_decode (
    input  logic                 gwe,
    input  logic                 i_reset,
    input  lc4_pkg::word_t       i_d_pc,
    input  lc4_pkg::word_t       i_d_insn,
    input  lc4_pkg::stall_code_t i_d_stall,
    input  logic                 i_flush,
    input  logic                 i_w_we,
    input  lc4_pkg::reg_idx_t    i_w_wsel,
    input  lc4_pkg::word_t       i_w_data,
    output logic                 o_load_stall,
    output lc4_pkg::word_t       o_x_pc,
    output lc4_pkg::word_t       o_x_insn,
    output lc4_pkg::stall_code_t o_x_stall,
    output lc4_pkg::reg_idx_t    o_x_rs_sel,
    output lc4_pkg::reg_idx_t    o_x_rt_sel,
    output logic                 o_x_rs_re,
    output logic                 o_x_rt_re,
    output lc4_pkg::reg_idx_t    o_x_wsel,
    output logic                 o_x_regfile_we,
    output logic                 o_x_nzp_we,
    output logic                 o_x_is_load,
    output logic                 o_x_is_store,
    output logic                 o_x_is_branch,
    output lc4_pkg::word_t       o_x_rs_data,
    output lc4_pkg::word_t       o_x_rt_data
);

    lc4_pkg::reg_idx_t rs_sel;
    lc4_pkg::reg_idx_t rt_sel;
    lc4_pkg::word_t    rs_data;
    lc4_pkg::word_t    rt_data;
    logic              op_kept;
    logic              rs_re;
    logic              rt_re;
    logic              regfile_we;
    logic              is_load;
    logic              is_store;
    logic              is_branch;

    // store data register sits in the rd field
    assign rs_sel = i_d_insn[8:6];
    assign rt_sel = (i_d_insn[15:12] == lc4_pkg::OPC_STR) ? i_d_insn[11:9] : i_d_insn[2:0];

    // add/sub/addi and and/or/xor/andi, mul, div and not fall out here
    assign op_kept = i_d_insn[5] || !i_d_insn[3]
                     || (i_d_insn[15:12] == lc4_pkg::OPC_LOGIC && i_d_insn[4]);

    always_comb begin
        rs_re      = 1'b0;
        rt_re      = 1'b0;
        regfile_we = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_branch  = 1'b0;
        if (i_d_stall == lc4_pkg::STALL_NONE) begin
            case (i_d_insn[15:12])
                lc4_pkg::OPC_ARITH, lc4_pkg::OPC_LOGIC: begin
                    rs_re      = op_kept;
                    rt_re      = op_kept && !i_d_insn[5];
                    regfile_we = op_kept;
                end
                lc4_pkg::OPC_CONST: regfile_we = 1'b1;
                lc4_pkg::OPC_LDR: begin
                    rs_re      = 1'b1;
                    regfile_we = 1'b1;
                    is_load    = 1'b1;
                end
                lc4_pkg::OPC_STR: begin
                    rs_re    = 1'b1;
                    rt_re    = 1'b1;
                    is_store = 1'b1;
                end
                lc4_pkg::OPC_BR: is_branch = 1'b1;
                default: ;
            endcase
        end
    end

    // store data from a load is covered by the wm bypass, so it does not stall
    assign o_load_stall = o_x_is_load && ((rs_re && rs_sel == o_x_wsel)
                          || (rt_re && !is_store && rt_sel == o_x_wsel) || is_branch);

    lc4_regfile regfile0 (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .i_we      (i_w_we),
        .i_wsel    (i_w_wsel),
        .i_wdata   (i_w_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    always_ff @(posedge gwe) begin
        o_x_pc      <= i_d_pc;
        o_x_insn    <= i_d_insn;
        o_x_rs_sel  <= rs_sel;
        o_x_rt_sel  <= rt_sel;
        o_x_wsel    <= i_d_insn[11:9];
        o_x_rs_data <= rs_data;
        o_x_rt_data <= rt_data;
    end

    always_ff @(posedge gwe) begin
        if (i_reset || i_flush || o_load_stall) begin
            o_x_stall      <= o_load_stall && !i_reset && !i_flush ? lc4_pkg::STALL_LOAD
                                                                   : lc4_pkg::STALL_FLUSH;
            o_x_rs_re      <= 1'b0;
            o_x_rt_re      <= 1'b0;
            o_x_regfile_we <= 1'b0;
            o_x_nzp_we     <= 1'b0;
            o_x_is_load    <= 1'b0;
            o_x_is_store   <= 1'b0;
            o_x_is_branch  <= 1'b0;
        end else begin
            o_x_stall      <= i_d_stall;
            o_x_rs_re      <= rs_re;
            o_x_rt_re      <= rt_re;
            o_x_regfile_we <= regfile_we;
            // every register writer also sets nzp
            o_x_nzp_we     <= regfile_we;
            o_x_is_load    <= is_load;
            o_x_is_store   <= is_store;
            o_x_is_branch  <= is_branch;
        end
    end

endmodule

//--- verilog/lc4_regfile.sv
`timescale 1ns/1ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_reset,
    input  lc4_pkg::reg_idx_t i_rs_sel,
    input  lc4_pkg::reg_idx_t i_rt_sel,
    input  logic              i_we,
    input  lc4_pkg::reg_idx_t i_wsel,
    input  lc4_pkg::word_t    i_wdata,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);

    lc4_pkg::word_t regs [0:7];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign o_rs_data = (i_we && i_wsel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_wsel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

//--- verilog/lc4_fetch.sv
`timescale 1ns/1ps

module lc4_fetch (
    input  logic                 gwe,
    input  logic                 i_reset,
    input  logic                 i_load_stall,
    input  logic                 i_redirect,
    input  lc4_pkg::word_t       i_redirect_pc,
    input  lc4_pkg::word_t       i_imem_insn,
    output lc4_pkg::word_t       o_imem_addr,
    output lc4_pkg::word_t       o_d_pc,
    output lc4_pkg::word_t       o_d_insn,
    output lc4_pkg::stall_code_t o_d_stall
);

    lc4_pkg::word_t pc;

    assign o_imem_addr = pc;

    // redirect wins over a stall, a load never sits in execute with a taken branch
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= lc4_pkg::RESET_PC;
        end else if (i_redirect) begin
            pc <= i_redirect_pc;
        end else if (!i_load_stall) begin
            pc <= pc + 16'd1;
        end
    end

    // decode slot payload, held while decode is stalled
    always_ff @(posedge gwe) begin
        if (!i_load_stall) begin
            o_d_pc   <= pc;
            o_d_insn <= i_imem_insn;
        end
    end

    // wrong-path or reset slot becomes a flush bubble
    always_ff @(posedge gwe) begin
        if (i_reset || i_redirect) begin
            o_d_stall <= lc4_pkg::STALL_FLUSH;
        end else if (!i_load_stall) begin
            o_d_stall <= lc4_pkg::STALL_NONE;
        end
    end

endmodule

//--- verilog/lc4_pkg.sv
package lc4_pkg;

    // data word, instruction word or program counter
    typedef logic [15:0] word_t;

    // register file index, r0..r7
    typedef logic [2:0] reg_idx_t;

    // condition bits, n is bit 2, z is bit 1, p is bit 0
    typedef logic [2:0] nzp_t;

    // what a pipeline slot holds, also shown on the trace
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,
        STALL_LOAD  = 2'd3
    } stall_code_t;

    // opcodes of the supported subset, insn[15:12]
    typedef enum logic [3:0] {
        OPC_BR    = 4'b0000,
        OPC_ARITH = 4'b0001,
        OPC_LOGIC = 4'b0101,
        OPC_LDR   = 4'b0110,
        OPC_STR   = 4'b0111,
        OPC_CONST = 4'b1001
    } opcode_t;

    // first fetch address after reset
    localparam word_t RESET_PC = 16'h8200;

endpackage
